// ==== filelist.f ====
+incdir+test
rtl/video_pkg.sv
rtl/pixel_select.sv
rtl/color_ram.sv
rtl/pwm_dither.sv
rtl/video_out.sv
test/tb_video_out.sv

// ==== Makefile ====
# Verilator build and run for the video output stage

TOP := tb_video_out

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f rtl/*.sv test/*.sv test/*.svh
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_model.svh ====
// testbench model functions for random numbers, pixel select rules and expected DAC levels
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH
`default_nettype none

// one step of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// palette index that the selector registers for one set of inputs
function automatic video_pkg::color_index_t select_index(
	input logic                    vga_on,
	input logic                    hires,
	input logic                    nibble_low,
	input video_pkg::color_index_t tvdata,
	input video_pkg::color_index_t vgadata
);
	if (!vga_on)
		return tvdata;
	if (!hires)
		return vgadata;
	// two pixels per byte, both in the upper page
	if (nibble_low)
		return {video_pkg::hires_page, vgadata[3:0]};
	return {video_pkg::hires_page, vgadata[7:4]};
endfunction

function automatic logic select_blank(
	input logic vga_on,
	input logic tv_hblank,
	input logic tv_vblank,
	input logic vga_hblank
);
	if (vga_on)
		return vga_hblank || tv_vblank;
	return tv_hblank || tv_vblank;
endfunction

// line parity takes the top phase bit in VGA mode
function automatic video_pkg::pwm_phase_t select_phase(
	input logic       vga_on,
	input logic       vga_line,
	input logic [2:0] ph
);
	if (vga_on)
		return {vga_line, ph[1:0]};
	return ph;
endfunction

// coarse level, one step higher on set pattern bits, held at 3
function automatic video_pkg::dac_level_t expect_level(
	input video_pkg::dac_level_t  coarse,
	input video_pkg::fine_level_t fine,
	input video_pkg::pwm_phase_t  phase
);
	logic [7:0] pattern;
	pattern = video_pkg::pwm_pattern[fine];
	if (!pattern[phase])
		return coarse;
	if (coarse == 2'd3)
		return 2'd3;
	return coarse + 2'd1;
endfunction

`default_nettype wire
`endif

// ==== test/tb_video_out.sv ====
// testbench top for the video output stage with clock, reset, stimulus, model and checks
`timescale 1ns/1ps
`include "tb_model.svh"
`default_nettype none

module tb_video_out;

	// about twice the length of all tests together
	localparam int max_cycles = 4000;

	logic clk = 1'b0;
	logic rst_n;
	logic f0;
	logic start_out;
	logic vga_on;
	logic hires;
	logic tv_hblank;
	logic tv_vblank;
	logic vga_hblank;
	logic vga_line;
	video_pkg::color_index_t tvdata;
	video_pkg::color_index_t vgadata;
	video_pkg::color_index_t pal_addr_in;
	video_pkg::rgb15_t pal_data_in;
	logic pal_we;
	video_pkg::dac_level_t vred;
	video_pkg::dac_level_t vgrn;
	video_pkg::dac_level_t vblu;

	// reference model state
	video_pkg::rgb15_t model_pal [0:video_pkg::pal_entries-1];
	logic [2:0] model_ph;
	logic model_nibble_low;
	video_pkg::color_index_t m_index;
	logic m_blank1;
	video_pkg::pwm_phase_t m_phase1;
	video_pkg::rgb15_t m_color;
	logic m_blank2;
	video_pkg::pwm_phase_t m_phase2;
	video_pkg::dac_level_t exp_red;
	video_pkg::dac_level_t exp_grn;
	video_pkg::dac_level_t exp_blu;

	logic [31:0] rng_state = 32'hc151;
	logic check_en = 1'b0;
	string test_name = "reset";
	int mismatch_count = 0;
	int timeout_count = 0;
	int cycle_count = 0;

	video_out dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.f0          (f0),
		.start_out   (start_out),
		.vga_on      (vga_on),
		.hires       (hires),
		.tv_hblank   (tv_hblank),
		.tv_vblank   (tv_vblank),
		.vga_hblank  (vga_hblank),
		.vga_line    (vga_line),
		.tvdata      (tvdata),
		.vgadata     (vgadata),
		.pal_addr_in (pal_addr_in),
		.pal_data_in (pal_data_in),
		.pal_we      (pal_we),
		.vred        (vred),
		.vgrn        (vgrn),
		.vblu        (vblu)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] next_random();
		rng_state = lcg_next(rng_state);
		return rng_state;
	endfunction

	task automatic report_mismatch(input string channel, input video_pkg::dac_level_t expected,
		input video_pkg::dac_level_t actual);
		mismatch_count++;
		$display("FAIL %s %s expected %0d actual %0d at %0t", test_name, channel, expected,
			actual, $time);
	endtask

	task automatic finish_run();
		$display("errors: %0d (value mismatches %0d, timeouts %0d)",
			mismatch_count + timeout_count, mismatch_count, timeout_count);
		if (mismatch_count + timeout_count == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	// three-stage model, walked from the output end so each stage sees last cycle's values
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			exp_red <= '0;
			exp_grn <= '0;
			exp_blu <= '0;
			m_color = '0;
			m_blank2 = 1'b0;
			m_phase2 = '0;
			m_index = '0;
			m_blank1 = 1'b1;
			m_phase1 = '0;
			model_ph = '0;
			model_nibble_low = 1'b0;
		end
		else
		begin
			if (m_blank2)
			begin
				exp_red <= '0;
				exp_grn <= '0;
				exp_blu <= '0;
			end
			else
			begin
				exp_red <= expect_level(m_color[14:13], m_color[12:10], m_phase2);
				exp_grn <= expect_level(m_color[9:8], m_color[7:5], m_phase2);
				exp_blu <= expect_level(m_color[4:3], m_color[2:0], m_phase2);
			end
			// palette read sees the word from before this edge's write
			m_color = model_pal[m_index];
			m_blank2 = m_blank1;
			m_phase2 = m_phase1;
			m_index = select_index(vga_on, hires, model_nibble_low, tvdata, vgadata);
			m_blank1 = select_blank(vga_on, tv_hblank, tv_vblank, vga_hblank);
			m_phase1 = select_phase(vga_on, vga_line, model_ph);
			model_ph = model_ph + 3'd1;
			if (f0)
				model_nibble_low = start_out ? 1'b0 : !model_nibble_low;
		end
		if (pal_we)
			model_pal[pal_addr_in] = pal_data_in;
	end

	red_check: assert property (@(posedge clk) check_en |-> (vred == exp_red))
		else report_mismatch("vred", $sampled(exp_red), $sampled(vred));
	grn_check: assert property (@(posedge clk) check_en |-> (vgrn == exp_grn))
		else report_mismatch("vgrn", $sampled(exp_grn), $sampled(vgrn));
	blu_check: assert property (@(posedge clk) check_en |-> (vblu == exp_blu))
		else report_mismatch("vblu", $sampled(exp_blu), $sampled(vblu));
	reset_dark: assert property (@(posedge clk)
		(check_en && !rst_n) |-> (vred == 2'd0) && (vgrn == 2'd0) && (vblu == 2'd0))
		else report_mismatch("reset level", 2'd0, $sampled(vred | vgrn | vblu));

	task automatic load_palette();
		logic [31:0] r;
		for (int i = 0; i < video_pkg::pal_entries; i++)
		begin
			r = next_random();
			@(posedge clk);
			pal_we <= 1'b1;
			pal_addr_in <= 8'(i);
			// full-scale words push every channel into saturation
			if (i % 32 == 5)
				pal_data_in <= 15'h7fff;
			else
				pal_data_in <= r[30:16];
		end
		@(posedge clk);
		pal_we <= 1'b0;
	endtask

	task automatic run_tv(input int cycles, input logic with_blank);
		logic [31:0] r;
		for (int i = 0; i < cycles; i++)
		begin
			r = next_random();
			@(posedge clk);
			vga_on <= 1'b0;
			hires <= 1'b0;
			tvdata <= r[23:16];
			f0 <= r[24];
			tv_hblank <= with_blank && (r[27:25] == 3'd0);
			tv_vblank <= with_blank && (r[30:28] == 3'd0);
			vga_hblank <= r[31];
		end
	endtask

	task automatic run_vga(input int cycles, input logic with_blank, input logic hires_mode);
		logic [31:0] r;
		logic [31:0] s;
		for (int i = 0; i < cycles; i++)
		begin
			r = next_random();
			s = next_random();
			@(posedge clk);
			vga_on <= 1'b1;
			hires <= hires_mode;
			vgadata <= r[23:16];
			tvdata <= r[31:24];
			vga_line <= s[16] ? !vga_line : vga_line;
			f0 <= s[17];
			start_out <= (s[20:18] == 3'd0);
			vga_hblank <= with_blank && (s[23:21] == 3'd0);
			tv_vblank <= with_blank && (s[26:24] == 3'd0);
			// ignored while VGA is selected
			tv_hblank <= s[27];
		end
	endtask

	initial
	begin
		rst_n = 1'b0;
		f0 = 1'b0;
		start_out = 1'b0;
		vga_on = 1'b0;
		hires = 1'b0;
		tv_hblank = 1'b1;
		tv_vblank = 1'b0;
		vga_hblank = 1'b0;
		vga_line = 1'b0;
		tvdata = '0;
		vgadata = '0;
		pal_addr_in = '0;
		pal_data_in = '0;
		pal_we = 1'b0;
		@(posedge clk);
		check_en <= 1'b1;
		repeat (7) @(posedge clk);
		rst_n <= 1'b1;
		// blanking stays on while the palette fills
		test_name = "palette_load";
		load_palette();
		test_name = "tv_path";
		run_tv(300, 1'b0);
		test_name = "blank_tv";
		run_tv(200, 1'b1);
		test_name = "blank_vga";
		run_vga(200, 1'b1, 1'b0);
		test_name = "vga_path";
		run_vga(300, 1'b0, 1'b0);
		test_name = "hires";
		run_vga(400, 1'b0, 1'b1);
		@(posedge clk);
		tv_vblank <= 1'b1;
		repeat (4) @(posedge clk);
		finish_run();
	end

	initial
	begin
		while (cycle_count < max_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		timeout_count++;
		$display("timeout: the run was still going after %0d cycles", max_cycles);
		finish_run();
	end

endmodule

`default_nettype wire

// ==== rtl/video_out.sv ====
// video output stage top with pixel selector, palette RAM and dither stage
`timescale 1ns/1ps
`default_nettype none

module video_out (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          f0,
	input  wire                          start_out,
	input  wire                          vga_on,
	input  wire                          hires,
	input  wire                          tv_hblank,
	input  wire                          tv_vblank,
	input  wire                          vga_hblank,
	input  wire                          vga_line,
	input  wire video_pkg::color_index_t tvdata,
	input  wire video_pkg::color_index_t vgadata,
	input  wire video_pkg::color_index_t pal_addr_in,
	input  wire video_pkg::rgb15_t       pal_data_in,
	input  wire                          pal_we,
	output wire video_pkg::dac_level_t   vred,
	output wire video_pkg::dac_level_t   vgrn,
	output wire video_pkg::dac_level_t   vblu
);

	wire video_pkg::color_index_t sel_index;
	wire sel_blank;
	wire video_pkg::pwm_phase_t sel_phase;
	wire video_pkg::rgb15_t pixel_color;
	wire pipe_blank;
	wire video_pkg::pwm_phase_t pipe_phase;

	// stage 1, source select
	pixel_select u_pixel_select (
		.clk        (clk),
		.rst_n      (rst_n),
		.f0         (f0),
		.start_out  (start_out),
		.vga_on     (vga_on),
		.hires      (hires),
		.tv_hblank  (tv_hblank),
		.tv_vblank  (tv_vblank),
		.vga_hblank (vga_hblank),
		.vga_line   (vga_line),
		.tvdata     (tvdata),
		.vgadata    (vgadata),
		.sel_index  (sel_index),
		.sel_blank  (sel_blank),
		.sel_phase  (sel_phase)
	);

	// stage 2, palette lookup
	color_ram u_color_ram (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr_addr     (pal_addr_in),
		.wr_data     (pal_data_in),
		.wr_en       (pal_we),
		.rd_addr     (sel_index),
		.in_blank    (sel_blank),
		.in_phase    (sel_phase),
		.pixel_color (pixel_color),
		.pipe_blank  (pipe_blank),
		.pipe_phase  (pipe_phase)
	);

	// stage 3, dither to DAC levels
	pwm_dither u_pwm_dither (
		.clk         (clk),
		.rst_n       (rst_n),
		.pixel_color (pixel_color),
		.in_blank    (pipe_blank),
		.in_phase    (pipe_phase),
		.vred        (vred),
		.vgrn        (vgrn),
		.vblu        (vblu)
	);

endmodule

`default_nettype wire

// ==== rtl/pwm_dither.sv ====
// pulse-pattern dither per channel with saturation and registered DAC levels
`timescale 1ns/1ps
`default_nettype none

module pwm_dither (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire video_pkg::rgb15_t     pixel_color,
	input  wire                        in_blank,
	input  wire video_pkg::pwm_phase_t in_phase,
	output video_pkg::dac_level_t      vred,
	output video_pkg::dac_level_t      vgrn,
	output video_pkg::dac_level_t      vblu
);

	video_pkg::dac_level_t red_coarse;
	video_pkg::dac_level_t grn_coarse;
	video_pkg::dac_level_t blu_coarse;
	video_pkg::fine_level_t red_fine;
	video_pkg::fine_level_t grn_fine;
	video_pkg::fine_level_t blu_fine;
	video_pkg::dac_level_t red_level;
	video_pkg::dac_level_t grn_level;
	video_pkg::dac_level_t blu_level;

	// one coarse step up when the pattern bit is set, held at the top level
	function automatic video_pkg::dac_level_t dither_level(
		input video_pkg::dac_level_t  coarse,
		input video_pkg::fine_level_t fine,
		input video_pkg::pwm_phase_t  phase
	);
		logic bump;
		bump = video_pkg::pwm_pattern[fine][phase];
		if (bump && (coarse != 2'd3))
			dither_level = coarse + 2'd1;
		else
			dither_level = coarse;
	endfunction

	// palette word fields
	assign red_coarse = pixel_color[14:13];
	assign red_fine   = pixel_color[12:10];
	assign grn_coarse = pixel_color[9:8];
	assign grn_fine   = pixel_color[7:5];
	assign blu_coarse = pixel_color[4:3];
	assign blu_fine   = pixel_color[2:0];

	assign red_level = dither_level(red_coarse, red_fine, in_phase);
	assign grn_level = dither_level(grn_coarse, grn_fine, in_phase);
	assign blu_level = dither_level(blu_coarse, blu_fine, in_phase);

	// output register, forced dark while blanking
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
		end
		else if (in_blank)
		begin
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
		end
		else
		begin
			vred <= red_level;
			vgrn <= grn_level;
			vblu <= blu_level;
		end
	end

	a_blank_dark: assert property (@(posedge clk) disable iff (!rst_n)
		in_blank |=> (vred == '0) && (vgrn == '0) && (vblu == '0));

endmodule

`default_nettype wire

// ==== rtl/color_ram.sv ====
// palette RAM with one write port, registered read and blank/phase alignment
`timescale 1ns/1ps
`default_nettype none

module color_ram (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire video_pkg::color_index_t wr_addr,
	input  wire video_pkg::rgb15_t       wr_data,
	input  wire                          wr_en,
	input  wire video_pkg::color_index_t rd_addr,
	input  wire                          in_blank,
	input  wire video_pkg::pwm_phase_t   in_phase,
	output video_pkg::rgb15_t            pixel_color,
	output logic                         pipe_blank,
	output video_pkg::pwm_phase_t        pipe_phase
);

	video_pkg::rgb15_t mem [0:video_pkg::pal_entries-1];

	// CPU write port
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// read returns the old word on a same-address write
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			pixel_color <= '0;
		else
			pixel_color <= mem[rd_addr];
	end

	// blank and phase follow the read data by one cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			pipe_blank <= 1'b0;
			pipe_phase <= '0;
		end
		else
		begin
			pipe_blank <= in_blank;
			pipe_phase <= in_phase;
		end
	end

	a_we_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(wr_en));

endmodule

`default_nettype wire

// ==== rtl/pixel_select.sv ====
// pixel selector with TV/VGA mux, hi-res nibble split, blanking and dither phase counter
`timescale 1ns/1ps
`default_nettype none

module pixel_select (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        f0,
	input  wire                        start_out,
	input  wire                        vga_on,
	input  wire                        hires,
	input  wire                        tv_hblank,
	input  wire                        tv_vblank,
	input  wire                        vga_hblank,
	input  wire                        vga_line,
	input  wire video_pkg::color_index_t tvdata,
	input  wire video_pkg::color_index_t vgadata,
	output video_pkg::color_index_t    sel_index,
	output logic                       sel_blank,
	output video_pkg::pwm_phase_t      sel_phase
);

	logic [2:0] ph;
	logic hires_sel;
	video_pkg::color_index_t hires_index;
	video_pkg::color_index_t next_index;
	logic next_blank;
	video_pkg::pwm_phase_t next_phase;

	// free-running dither phase
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			ph <= 3'd0;
		else
			ph <= ph + 3'd1;
	end

	// nibble toggle, advanced on pixel strobes, restarted by start_out
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			hires_sel <= 1'b0;
		else if (f0)
			hires_sel <= start_out ? 1'b0 : ~hires_sel;
	end

	// hi-res byte gives two indices in the upper page, high nibble first
	assign hires_index = {video_pkg::hires_page, hires_sel ? vgadata[3:0] : vgadata[7:4]};

	assign next_index = vga_on ? (hires ? hires_index : vgadata) : tvdata;
	assign next_blank = vga_on ? (vga_hblank | tv_vblank) : (tv_hblank | tv_vblank);

	// in VGA mode line parity replaces the top phase bit
	assign next_phase = vga_on ? {vga_line, ph[1:0]} : ph;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sel_index <= '0;
			sel_blank <= 1'b1;
			sel_phase <= '0;
		end
		else
		begin
			sel_index <= next_index;
			sel_blank <= next_blank;
			sel_phase <= next_phase;
		end
	end

	a_hires_page: assert property (@(posedge clk) disable iff (!rst_n)
		(vga_on && hires) |=> (sel_index[7:4] == video_pkg::hires_page));

endmodule

`default_nettype wire

// ==== rtl/video_pkg.sv ====
// video output stage package with vector types, palette size, dither patterns and hi-res page
`default_nettype none

package video_pkg;

	// palette index, the pixel value from the TV or VGA source
	typedef logic [7:0] color_index_t;

	// palette word, 2 coarse and 3 fine bits per channel, red on top
	typedef logic [14:0] rgb15_t;

	// level for one channel of the resistor DAC
	typedef logic [1:0] dac_level_t;

	// dither phase within the eight-step pulse cycle
	typedef logic [2:0] pwm_phase_t;

	// fine intensity that picks a pulse pattern
	typedef logic [2:0] fine_level_t;

	// palette depth
	localparam int pal_entries = 256;

	// upper palette page used by hi-res nibble indices
	localparam logic [3:0] hires_page = 4'b1111;

	// level n sets n of the eight phase bits, spread over the cycle
	localparam logic [7:0] pwm_pattern [0:7] = '{
		8'b00000000,
		8'b00000001,
		8'b01000001,
		8'b01000101,
		8'b10100101,
		8'b10100111,
		8'b11010111,
		8'b11011111
	};

endpackage

`default_nettype wire
